// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = icache_tb
FILELIST  = icache.f
PASS_MSG  = Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== icache.f ====
+incdir+verif
logic/icache_pkg.sv
logic/fetch_req_stage.sv
logic/icache_ctrl.sv
logic/icache_tag_array.sv
logic/icache_data_array.sv
logic/inst_align.sv
logic/icache_top.sv
verif/icache_tb.sv

// ==== logic/fetch_req_stage.sv ====
module fetch_req_stage #(
  parameter logic [31:0] UNCACHE_BASE  = 32'h0000_0000,
  parameter logic [31:0] UNCACHE_LIMIT = 32'h0000_0000
) (
  input  logic                    clk,
  input  logic                    rst,
  input  icache_pkg::fetch_addr_u fetch_addr_i,
  input  logic                    fetch_valid_i,
  input  logic                    idle_i,
  output icache_pkg::fetch_req_t  req_o,
  output logic                    start_o
);

  logic in_window;
  logic accept;

  // uncacheable window, base inclusive, limit exclusive
  assign in_window = (fetch_addr_i.raw >= UNCACHE_BASE) &&
                     (fetch_addr_i.raw < UNCACHE_LIMIT);

  // strobe only counts while the controller waits for work
  assign accept = fetch_valid_i & idle_i;

  // start reaches the controller one edge after the strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      start_o <= 1'b0;
    end else begin
      start_o <= accept;
    end
  end

  // request held for the whole lookup, refill or bypass read
  always_ff @(posedge clk) begin
    if (accept) begin
      req_o.addr     <= fetch_addr_i;
      req_o.uncached <= in_window;
    end
  end

  // fetch unit waits for the response pulse before the next strobe,
  // so every strobe must find the controller idle
  a_strobe_when_idle : assert property (
    @(posedge clk) disable iff (rst)
    fetch_valid_i |-> idle_i
  );

endmodule

// ==== logic/icache_ctrl.sv ====
module icache_ctrl (
  input  logic                     clk,
  input  logic                     rst,
  input  icache_pkg::fetch_req_t   req_i,
  input  logic                     start_i,
  input  logic                     hit_i,
  input  logic                     mem_rvalid_i,
  input  logic [31:0]              mem_rdata_i,
  output logic                     idle_o,
  output icache_pkg::mem_req_t     mem_req_o,
  output logic                     mem_req_valid_o,
  output icache_pkg::refill_beat_t beat_o,
  output logic                     tag_wr_o,
  output logic                     hit_pulse_o,
  output logic                     unc_done_o,
  output logic [31:0]              unc_data_o
);

  import icache_pkg::*;

  typedef enum logic [2:0] {
    ST_RESET,
    ST_IDLE,
    ST_LOOKUP,
    ST_REFILL,
    ST_UNC
  } state_t;

  state_t            state_q;
  logic [WSEL_W-1:0] beat_cnt_q;
  logic              beat_fire;
  logic              last_beat;
  logic              need_mem;

  // one beat per cycle with data valid while the request is up
  assign beat_fire = mem_req_valid_o & mem_rvalid_i;
  assign last_beat = beat_cnt_q == mem_req_o.len[WSEL_W-1:0];
  // lookup that goes out to memory, either miss or bypass
  assign need_mem  = (state_q == ST_LOOKUP) & (req_i.uncached | ~hit_i);

  assign idle_o      = state_q == ST_IDLE;
  assign hit_pulse_o = (state_q == ST_LOOKUP) & ~req_i.uncached & hit_i;

  // each refill word written as it arrives
  assign beat_o.idx  = req_i.addr.f.idx;
  assign beat_o.word = beat_cnt_q;
  assign beat_o.data = mem_rdata_i;
  assign beat_o.we   = (state_q == ST_REFILL) & beat_fire;

  // tag goes valid together with the last word
  assign tag_wr_o = (state_q == ST_REFILL) & beat_fire & last_beat;

  // bypass word handed straight to the output register
  assign unc_done_o = (state_q == ST_UNC) & beat_fire;
  assign unc_data_o = mem_rdata_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q         <= ST_RESET;
      mem_req_valid_o <= 1'b0;
      beat_cnt_q      <= '0;
    end else begin
      case (state_q)
        ST_RESET: state_q <= ST_IDLE;
        ST_IDLE: begin
          if (start_i) begin
            state_q <= ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          beat_cnt_q <= '0;
          if (req_i.uncached) begin
            mem_req_valid_o <= 1'b1;
            state_q         <= ST_UNC;
          end else if (hit_i) begin
            state_q <= ST_IDLE;
          end else begin
            mem_req_valid_o <= 1'b1;
            state_q         <= ST_REFILL;
          end
        end
        ST_REFILL: begin
          if (beat_fire) begin
            if (last_beat) begin
              mem_req_valid_o <= 1'b0;
              // second lookup now hits
              state_q <= ST_LOOKUP;
            end else begin
              beat_cnt_q <= beat_cnt_q + 1'b1;
            end
          end
        end
        ST_UNC: begin
          if (beat_fire) begin
            mem_req_valid_o <= 1'b0;
            state_q         <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // request word stays constant while valid is up
  always_ff @(posedge clk) begin
    if (need_mem) begin
      if (req_i.uncached) begin
        mem_req_o.addr <= req_i.addr.raw;
        mem_req_o.len  <= 8'd0;
      end else begin
        // line base
        mem_req_o.addr <= {req_i.addr.f.tag, req_i.addr.f.idx, {OFS_W{1'b0}}};
        mem_req_o.len  <= 8'(BEATS_PER_LINE - 1);
      end
    end
  end

  // burst counter only climbs during a refill, a wrap means it ran past the length
  a_beat_bound : assert property (
    @(posedge clk) disable iff (rst)
    (state_q == ST_REFILL && $past(state_q == ST_REFILL)) |->
      (beat_cnt_q >= $past(beat_cnt_q))
  );

  // request drops only after the final beat of the burst
  a_valid_hold : assert property (
    @(posedge clk) disable iff (rst)
    $fell(mem_req_valid_o) |-> $past(beat_fire && (last_beat || state_q == ST_UNC))
  );

endmodule

// ==== logic/icache_data_array.sv ====
module icache_data_array (
  input  logic                        clk,
  input  icache_pkg::fetch_req_t      req_i,
  input  icache_pkg::refill_beat_t    beat_i,
  output icache_pkg::inst_word_pair_t words_o
);

  import icache_pkg::*;

  localparam int WORDS = (2 ** IDX_W) * BEATS_PER_LINE;

  // flat store, line index above word select
  logic [31:0] mem_q [WORDS];

  logic [IDX_W-1:0]  rd_idx;
  logic [WSEL_W-1:0] rd_word;
  logic [WSEL_W-1:0] nxt_word;
  logic              at_line_end;

  // one word per refill beat
  always_ff @(posedge clk) begin
    if (beat_i.we) begin
      mem_q[{beat_i.idx, beat_i.word}] <= beat_i.data;
    end
  end

  assign rd_idx      = req_i.addr.f.idx;
  // byte offset bits 5:2 pick the word
  assign rd_word     = req_i.addr.f.ofs[OFS_W-1:2];
  assign nxt_word    = rd_word + 1'b1;
  assign at_line_end = rd_word == WSEL_W'(BEATS_PER_LINE - 1);

  assign words_o.cur = mem_q[{rd_idx, rd_word}];
  // no cross-line read, last word has no successor
  assign words_o.nxt = at_line_end ? 32'd0 : mem_q[{rd_idx, nxt_word}];

endmodule

// ==== logic/icache_pkg.sv ====
package icache_pkg;

  // address split for 8 KiB, 128 lines of 64 bytes
  localparam int TAG_W = 19;
  localparam int IDX_W = 7;
  localparam int OFS_W = 6;

  // refill burst, one 32-bit word per beat
  localparam int BEATS_PER_LINE = 16;
  // word select inside a line
  localparam int WSEL_W = 4;

  // fields view of a fetch address
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [IDX_W-1:0] idx;
    logic [OFS_W-1:0] ofs;
  } fetch_fields_t;

  // raw form goes to memory, fields form goes to the arrays
  typedef union packed {
    logic [31:0]   raw;
    fetch_fields_t f;
  } fetch_addr_u;

  // captured request plus window check result
  typedef struct packed {
    fetch_addr_u addr;
    logic        uncached;
  } fetch_req_t;

  // len is beat count minus one
  typedef struct packed {
    logic [31:0] addr;
    logic [7:0]  len;
  } mem_req_t;

  // one refill word on its way into the data store
  typedef struct packed {
    logic [IDX_W-1:0]  idx;
    logic [WSEL_W-1:0] word;
    logic [31:0]       data;
    logic              we;
  } refill_beat_t;

  // word at the offset and the one after it
  typedef struct packed {
    logic [31:0] cur;
    logic [31:0] nxt;
  } inst_word_pair_t;

  typedef struct packed {
    logic [31:0] data;
    logic        valid;
  } fetch_resp_t;

endpackage

// ==== logic/icache_tag_array.sv ====
module icache_tag_array (
  input  logic                   clk,
  input  logic                   rst,
  input  icache_pkg::fetch_req_t req_i,
  input  logic                   tag_wr_i,
  output logic                   hit_o
);

  import icache_pkg::*;

  localparam int LINES = 2 ** IDX_W;

  // valid bits are control state, tags are payload
  logic [LINES-1:0] valid_q;
  logic [TAG_W-1:0] tag_q [LINES];

  logic [IDX_W-1:0] idx;
  logic [TAG_W-1:0] tag;

  assign idx = req_i.addr.f.idx;
  assign tag = req_i.addr.f.tag;

  // compare against the captured request
  assign hit_o = valid_q[idx] && (tag_q[idx] == tag);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (tag_wr_i) begin
      valid_q[idx] <= 1'b1;
    end
  end

  // tag written at the end of a refill
  always_ff @(posedge clk) begin
    if (tag_wr_i) begin
      tag_q[idx] <= tag;
    end
  end

endmodule

// ==== logic/icache_top.sv ====
module icache_top #(
  parameter logic [31:0] UNCACHE_BASE  = 32'hA000_0000,
  parameter logic [31:0] UNCACHE_LIMIT = 32'hC000_0000
) (
  input  logic                    clk,
  input  logic                    rst,
  input  icache_pkg::fetch_addr_u fetch_addr_i,
  input  logic                    fetch_valid_i,
  output icache_pkg::fetch_resp_t fetch_resp_o,
  output icache_pkg::mem_req_t    mem_req_o,
  output logic                    mem_req_valid_o,
  input  logic                    mem_rvalid_i,
  input  logic [31:0]             mem_rdata_i
);

  import icache_pkg::*;

  // request side
  fetch_req_t      req;
  logic            start;
  logic            idle;

  // controller to arrays and output side
  refill_beat_t    beat;
  logic            tag_wr;
  logic            hit;
  logic            hit_pulse;
  logic            unc_done;
  logic [31:0]     unc_data;
  inst_word_pair_t words;

  fetch_req_stage #(
    .UNCACHE_BASE  (UNCACHE_BASE),
    .UNCACHE_LIMIT (UNCACHE_LIMIT)
  ) u_req (
    .clk           (clk),
    .rst           (rst),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_valid_i (fetch_valid_i),
    .idle_i        (idle),
    .req_o         (req),
    .start_o       (start)
  );

  icache_ctrl u_ctrl (
    .clk             (clk),
    .rst             (rst),
    .req_i           (req),
    .start_i         (start),
    .hit_i           (hit),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_rdata_i     (mem_rdata_i),
    .idle_o          (idle),
    .mem_req_o       (mem_req_o),
    .mem_req_valid_o (mem_req_valid_o),
    .beat_o          (beat),
    .tag_wr_o        (tag_wr),
    .hit_pulse_o     (hit_pulse),
    .unc_done_o      (unc_done),
    .unc_data_o      (unc_data)
  );

  icache_tag_array u_tags (
    .clk      (clk),
    .rst      (rst),
    .req_i    (req),
    .tag_wr_i (tag_wr),
    .hit_o    (hit)
  );

  icache_data_array u_data (
    .clk     (clk),
    .req_i   (req),
    .beat_i  (beat),
    .words_o (words)
  );

  inst_align u_align (
    .clk         (clk),
    .rst         (rst),
    .req_i       (req),
    .words_i     (words),
    .hit_pulse_i (hit_pulse),
    .unc_done_i  (unc_done),
    .unc_data_i  (unc_data),
    .resp_o      (fetch_resp_o)
  );

endmodule

// ==== logic/inst_align.sv ====
module inst_align (
  input  logic                        clk,
  input  logic                        rst,
  input  icache_pkg::fetch_req_t      req_i,
  input  icache_pkg::inst_word_pair_t words_i,
  input  logic                        hit_pulse_i,
  input  logic                        unc_done_i,
  input  logic [31:0]                 unc_data_i,
  output icache_pkg::fetch_resp_t     resp_o
);

  logic        upper_half;
  logic [15:0] lo_half;
  logic [15:0] hi_half;
  logic        is_rv32;
  logic [31:0] inst;

  // offset bit 1 selects the halfword inside the current word
  assign upper_half = req_i.addr.f.ofs[1];

  assign lo_half = upper_half ? words_i.cur[31:16] : words_i.cur[15:0];
  // upper half of a 32-bit instruction may sit in the next word
  assign hi_half = upper_half ? words_i.nxt[15:0] : words_i.cur[31:16];

  // low bits 11 mark a full-size instruction
  assign is_rv32 = lo_half[1:0] == 2'b11;

  always_comb begin
    if (is_rv32) begin
      inst = {hi_half, lo_half};
    end else begin
      // compressed, zero-extended
      inst = {16'd0, lo_half};
    end
  end

  // one-cycle valid, follows either source by one edge
  always_ff @(posedge clk) begin
    if (rst) begin
      resp_o.valid <= 1'b0;
    end else begin
      resp_o.valid <= hit_pulse_i | unc_done_i;
    end
  end

  always_ff @(posedge clk) begin
    if (hit_pulse_i) begin
      resp_o.data <= inst;
    end else if (unc_done_i) begin
      // bypass read returns the raw word
      resp_o.data <= unc_data_i;
    end
  end

  // hit path and bypass path never finish together
  a_one_source : assert property (
    @(posedge clk) disable iff (rst)
    !(hit_pulse_i && unc_done_i)
  );

endmodule

// ==== verif/icache_tb_model.svh ====
`ifndef ICACHE_TB_MODEL_SVH
`define ICACHE_TB_MODEL_SVH

// line state the cache should hold
logic [127:0] model_valid;
logic [18:0]  model_tag [128];
// fetches strobed but not yet answered
int           pending;

function automatic logic is_uncached(input logic [31:0] addr);
  return (addr >= 32'hA000_0000) && (addr < 32'hC000_0000);
endfunction

// memory word at byte address a
function automatic logic [31:0] mem_word(input logic [31:0] a);
  logic [31:0] h;
  logic [1:0]  lo_bits;
  logic [1:0]  hi_bits;
  h = (a ^ (a >> 13)) * 32'h2545_F491;
  h = h ^ (h >> 16);
  // 32-bit start in the low half when word bit 1 is set
  lo_bits = a[3] ? 2'b11 : {h[0], 1'b0};
  // odd words and the last word of a line start one in the high half
  hi_bits = (a[2] || a[5:2] == 4'hf) ? 2'b11 : {h[1], 1'b0};
  return {h[31:18], hi_bits, h[15:2], lo_bits};
endfunction

function automatic logic [31:0] expect_inst(input logic [31:0] addr);
  logic [31:0] cur;
  logic [31:0] nxt;
  logic [15:0] lo;
  logic [15:0] hi;
  if (is_uncached(addr)) begin
    return mem_word(addr);
  end
  cur = mem_word({addr[31:2], 2'b00});
  nxt = mem_word({addr[31:2], 2'b00} + 32'd4);
  lo  = addr[1] ? cur[31:16] : cur[15:0];
  // upper half from the next word, zero past the line end
  hi  = !addr[1] ? cur[31:16] : (addr[5:2] == 4'hf) ? 16'd0 : nxt[15:0];
  return (lo[1:0] == 2'b11) ? {hi, lo} : {16'd0, lo};
endfunction

function automatic logic model_hit(input logic [31:0] addr);
  return !is_uncached(addr) && model_valid[addr[12:6]] && model_tag[addr[12:6]] == addr[31:13];
endfunction

`endif

// ==== verif/icache_tb.sv ====
module icache_tb;

  import icache_pkg::*;

  localparam int DIRECTED_FETCHES = 41;
  localparam int RANDOM_FETCHES   = 300;
  localparam int CYCLE_LIMIT      = 400 * (DIRECTED_FETCHES + RANDOM_FETCHES);

  logic        clk;
  logic        rst;
  fetch_addr_u fetch_addr_i;
  logic        fetch_valid_i;
  fetch_resp_t fetch_resp_o;
  mem_req_t    mem_req_o;
  logic        mem_req_valid_o;
  logic        mem_rvalid_i = 1'b0;
  logic [31:0] mem_rdata_i  = 32'd0;

  logic [31:0] stim_seed = 32'd99;
  logic [31:0] mem_seed  = 32'd99;
  int          cycles    = 0;
  // responding memory state
  logic        valid_seen = 1'b0;
  int          beat_num   = 0;
  mem_req_t    burst_req  = '0;

  `include "icache_tb_model.svh"

  icache_top i_dut (
    .clk             (clk),
    .rst             (rst),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_resp_o    (fetch_resp_o),
    .mem_req_o       (mem_req_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_rdata_i     (mem_rdata_i)
  );

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("Finished with errors");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_resp(input fetch_resp_t got, input fetch_resp_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("FAILED at %0t: fetch response %h valid %b, expected %h",
                                $time, got.data, got.valid, exp.data));
    end
  endtask

  task automatic check_mem_req(input mem_req_t got, input mem_req_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("FAILED at %0t: memory request %h len %0d, expected %h len %0d",
                                $time, got.addr, got.len, exp.addr, exp.len));
    end
  endtask

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // upper LCG bits only, few tags and lines so hits and conflicts mix
  function automatic logic [31:0] random_addr();
    stim_seed = lcg_step(stim_seed);
    if (stim_seed[31:29] == 3'd0) begin
      return 32'hA000_0000 + {16'd0, stim_seed[23:9], 1'b0};
    end
    return {16'h0001, 1'b0, stim_seed[28:27], 4'd0, stim_seed[26:24], stim_seed[23:19], 1'b0};
  endfunction

  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic do_fetch(input logic [31:0] addr);
    fetch_resp_t exp_resp;
    mem_req_t    exp_req;
    logic        hit;
    logic        saw_req;
    int          edges;
    hit            = model_hit(addr);
    saw_req        = 1'b0;
    edges          = 0;
    exp_resp.data  = expect_inst(addr);
    exp_resp.valid = 1'b1;
    // exact address for a bypass read, line base for a refill
    exp_req.addr   = is_uncached(addr) ? addr : {addr[31:6], 6'd0};
    exp_req.len    = is_uncached(addr) ? 8'd0 : 8'd15;
    fetch_addr_i.raw = addr;
    fetch_valid_i    = 1'b1;
    pending++;
    do begin
      tick();
      fetch_valid_i = 1'b0;
      edges++;
      if (mem_req_valid_o) begin
        if (hit) begin
          stop_with_error("a fetch that should hit raised a memory request");
        end
        check_mem_req(mem_req_o, exp_req);
        saw_req = 1'b1;
      end
    end while (!fetch_resp_o.valid);
    check_resp(fetch_resp_o, exp_resp);
    // strobe sampled at edge 1, response two edges later
    if (hit && edges != 3) begin
      stop_with_error($sformatf("FAILED at %0t: hit answered after %0d edges, expected 3",
                                $time, edges));
    end
    if (!hit && !saw_req) begin
      stop_with_error("a fetch that should miss finished without a memory request");
    end
    if (!hit && !is_uncached(addr)) begin
      model_valid[addr[12:6]] = 1'b1;
      model_tag[addr[12:6]]   = addr[31:13];
    end
    tick();
    if (fetch_resp_o.valid) begin
      stop_with_error("fetch response valid stayed high for more than one cycle");
    end
    pending--;
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      stop_with_error("timeout, the fetch sequence did not finish within the cycle limit");
    end
  end

  // a response pulse needs a fetch in flight
  always @(negedge clk) begin
    if (fetch_resp_o.valid === 1'b1 && pending == 0) begin
      stop_with_error("fetch response valid came with no fetch outstanding");
    end
  end

  // memory answers each beat after a random gap
  always @(posedge clk) begin
    #2;
    if (valid_seen && mem_rvalid_i) begin
      beat_num++;
    end
    if (valid_seen && !mem_req_valid_o) begin
      if (beat_num != int'(burst_req.len) + 1) begin
        stop_with_error("memory request dropped before its last beat");
      end
      beat_num = 0;
    end
    if (!valid_seen && mem_req_valid_o) begin
      burst_req = mem_req_o;
    end
    if (mem_req_valid_o && beat_num > int'(burst_req.len)) begin
      stop_with_error("memory request still high after its last beat");
    end
    valid_seen   = mem_req_valid_o;
    mem_seed     = lcg_step(mem_seed);
    mem_rvalid_i = mem_req_valid_o && (mem_seed[31:30] != 2'b00);
    mem_rdata_i  = mem_word(burst_req.addr + 32'(4 * beat_num));
  end

  initial begin
    rst           = 1'b1;
    fetch_valid_i = 1'b0;
    fetch_addr_i  = '0;
    model_valid   = '0;
    pending       = 0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    tick();
    // cold miss, then every halfword of that line
    for (int i = 0; i < 32; i++) begin
      do_fetch(32'h0000_4040 + 32'(2 * i));
    end
    // same index, different tags
    for (int i = 0; i < 3; i++) begin
      do_fetch(32'h0000_208A);
      do_fetch(32'h0000_4096);
    end
    // bypass reads, one on the index of the held line
    do_fetch(32'hA000_0100);
    do_fetch(32'hB000_4046);
    do_fetch(32'h0000_4044);
    for (int i = 0; i < RANDOM_FETCHES; i++) begin
      do_fetch(random_addr());
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule
